//--- all.f
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/cache_bank.sv
hw/cache_controller.sv
hw/main_memory.sv
hw/cache_top.sv
testbench/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module cache_tb \
  -o cache_tb_sim &&
./obj_dir/cache_tb_sim ||
{
  echo "simulation run did not complete cleanly"
  exit 1
}

//--- testbench/cache_golden.txt
// kind (0 read, 1 write) addr wdata wstrb exp_rdata exp_resp (0 okay, 2 slverr), all hex
// write lines put 00000000 in exp_rdata, read lines put 00000000 in wdata and 0 in wstrb
0 00000000 00000000 0 00000000 0
0 00000004 00000000 0 00000004 0
0 0000001c 00000000 0 0000001c 0
0 00000018 00000000 0 00000018 0
0 000007f0 00000000 0 000007f0 0
1 00000020 aabbccdd 3 00000000 0
0 00000020 00000000 0 0000ccdd 0
1 00000020 11223344 8 00000000 0
0 00000020 00000000 0 1100ccdd 0
1 00000024 cafef00d f 00000000 0
0 00000024 00000000 0 cafef00d 0
1 00000028 00ee0000 4 00000000 0
0 00000028 00000000 0 00ee0028 0
1 0000002c 12345678 0 00000000 0
0 0000002c 00000000 0 0000002c 0
1 00000030 30303030 f 00000000 0
1 000000b0 b0b0b0b0 f 00000000 0
1 00000130 13013013 f 00000000 0
0 00000030 00000000 0 30303030 0
0 000000b0 00000000 0 b0b0b0b0 0
0 00000130 00000000 0 13013013 0
0 00000034 00000000 0 00000034 0
1 00000050 0a0a0a0a f 00000000 0
1 000000d0 0b0b0b0b f 00000000 0
0 00000050 00000000 0 0a0a0a0a 0
1 00000150 0c0c0c0c f 00000000 0
0 00000050 00000000 0 0a0a0a0a 0
0 000000d0 00000000 0 0b0b0b0b 0
0 00000150 00000000 0 0c0c0c0c 0
1 00001020 deadbeef f 00000000 2
0 00001020 00000000 0 00000000 2
0 00000020 00000000 0 1100ccdd 0
0 fffffff0 00000000 0 00000000 2
1 00002000 5a5a5a5a f 00000000 2
0 00000000 00000000 0 00000000 0
0 00000ffc 00000000 0 00000ffc 0
0 000000d4 00000000 0 000000d4 0
0 00000154 00000000 0 00000154 0

//--- testbench/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
  localparam int NUM_SETS = 8;
  localparam int MEM_LINES = 256;
  localparam int MEM_LATENCY = 4;
  localparam int MAX_LINES = 64;
  localparam int FIELDS = 6;
  localparam int unsigned RAND_SEED = 32'hf1411009;
  localparam logic [31:0] NO_ENTRY = 32'hffff_ffff;

  logic clk;
  logic reset;
  logic [31:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  cache_pkg::axi_resp_t bresp;
  logic bvalid;
  logic bready;
  logic [31:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  cache_pkg::axi_resp_t rresp;
  logic rvalid;
  logic rready;

  // six hex fields per transaction
  logic [31:0] gold [0:MAX_LINES*FIELDS-1];
  int num_lines;
  logic loaded;

  cache_top #(
    .NUM_SETS   (NUM_SETS),
    .MEM_LINES  (MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) UUT (
    .clk    (clk),
    .reset  (reset),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic load_golden();
    for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
      gold[i] = NO_ENTRY;
    end
    $readmemh("testbench/cache_golden.txt", gold);
    num_lines = 0;
    while (num_lines < MAX_LINES && gold[num_lines*FIELDS] != NO_ENTRY) begin
      if (gold[num_lines*FIELDS] > 32'd1) begin
        $display("golden line %0d has an unknown transaction kind", num_lines + 1);
        $display("sim failed");
        $fatal(1, "bad golden file");
      end
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("no transactions could be read from the golden file");
      $display("sim failed");
      $fatal(1, "empty golden file");
    end
  endtask

  // called right after a rising edge; leaves right after one
  task automatic axi_write(input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [31:0] exp_resp);
    cache_pkg::axi_resp_t held_resp;
    int stall;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge clk); while (!bvalid);
    held_resp = bresp;
    stall = $urandom % 4;
    // response must not move under back-pressure
    repeat (stall) begin
      @(posedge clk);
      check_value({name, " bvalid held"}, 32'd1, 32'(bvalid));
      check_value({name, " bresp held"}, 32'(held_resp), 32'(bresp));
    end
    bready <= 1'b1;
    @(posedge clk);
    check_value({name, " bvalid at transfer"}, 32'd1, 32'(bvalid));
    check_value({name, " bresp at transfer"}, 32'(held_resp), 32'(bresp));
    bready <= 1'b0;
    check_value({name, " bresp"}, exp_resp, 32'(held_resp));
  endtask

  task automatic axi_read(input string name, input logic [31:0] addr,
                          input logic [31:0] exp_data, input logic [31:0] exp_resp);
    cache_pkg::axi_resp_t held_resp;
    logic [31:0] held_data;
    int stall;
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    held_resp = rresp;
    held_data = rdata;
    stall = $urandom % 4;
    repeat (stall) begin
      @(posedge clk);
      check_value({name, " rvalid held"}, 32'd1, 32'(rvalid));
      check_value({name, " rresp held"}, 32'(held_resp), 32'(rresp));
      check_value({name, " rdata held"}, held_data, rdata);
    end
    rready <= 1'b1;
    @(posedge clk);
    check_value({name, " rvalid at transfer"}, 32'd1, 32'(rvalid));
    check_value({name, " rresp at transfer"}, 32'(held_resp), 32'(rresp));
    check_value({name, " rdata at transfer"}, held_data, rdata);
    rready <= 1'b0;
    check_value({name, " rresp"}, exp_resp, 32'(held_resp));
    // error reads carry no defined data
    if (exp_resp == 32'd0) begin
      check_value({name, " rdata"}, exp_data, held_data);
    end
  endtask

  task automatic run_transaction(input int idx);
    logic [31:0] kind;
    logic [31:0] addr;
    string name;
    kind = gold[idx*FIELDS];
    addr = gold[idx*FIELDS+1];
    name = $sformatf("line %0d %s %h", idx + 1, (kind == 32'd1) ? "write" : "read", addr);
    if (kind == 32'd1) begin
      axi_write(name, addr, gold[idx*FIELDS+2], gold[idx*FIELDS+3][3:0], gold[idx*FIELDS+5]);
    end else begin
      axi_read(name, addr, gold[idx*FIELDS+4], gold[idx*FIELDS+5]);
    end
  endtask

  // limit scales with the number of golden transactions
  initial begin
    int limit;
    wait (loaded);
    limit = num_lines * (2 * MEM_LATENCY + 16 + 3) + 20;
    repeat (limit) @(posedge clk);
    $display("timeout: transactions did not complete within %0d clock cycles", limit);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(RAND_SEED));
    clk     = 1'b0;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    loaded  = 1'b0;
    num_lines = 0;
    load_golden();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < num_lines; i++) begin
      run_transaction(i);
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- hw/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
  parameter int NUM_SETS    = 8,
  parameter int MEM_LINES   = 256,
  parameter int MEM_LATENCY = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cache_pkg::ADDR_BITS-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [cache_pkg::WORD_BITS-1:0] wdata,
  input  logic [cache_pkg::STRB_BITS-1:0] wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output cache_pkg::axi_resp_t            bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [cache_pkg::ADDR_BITS-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [cache_pkg::WORD_BITS-1:0] rdata,
  output cache_pkg::axi_resp_t            rresp,
  output logic                            rvalid,
  input  logic                            rready
);

  bank_if #(.NUM_SETS(NUM_SETS)) way0_if ();
  bank_if #(.NUM_SETS(NUM_SETS)) way1_if ();
  mem_if #(.MEM_LINES(MEM_LINES)) mem_bus ();

  cache_controller #(
    .NUM_SETS (NUM_SETS),
    .MEM_LINES(MEM_LINES)
  ) u_ctrl (
    .clk    (clk),
    .reset  (reset),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .way0   (way0_if.ctrl),
    .way1   (way1_if.ctrl),
    .mem    (mem_bus.ctrl)
  );

  cache_bank #(.NUM_SETS(NUM_SETS)) u_way0 (
    .clk  (clk),
    .reset(reset),
    .bank (way0_if.bank)
  );

  cache_bank #(.NUM_SETS(NUM_SETS)) u_way1 (
    .clk  (clk),
    .reset(reset),
    .bank (way1_if.bank)
  );

  main_memory #(
    .MEM_LINES  (MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_mem (
    .clk  (clk),
    .reset(reset),
    .mem  (mem_bus.mem)
  );

endmodule

//--- hw/main_memory.sv
`timescale 1ns/100ps

module main_memory #(
  parameter int MEM_LINES   = 256,
  parameter int MEM_LATENCY = 4
) (
  input logic clk,
  input logic reset,
  mem_if.mem  mem
);
  localparam int CNT_BITS   = $clog2(MEM_LATENCY + 1);
  localparam int LINE_BYTES = cache_pkg::LINE_BITS / 8;
  localparam int W          = cache_pkg::WORD_BITS;

  logic [cache_pkg::LINE_BITS-1:0] mem_arr [MEM_LINES];
  logic [CNT_BITS-1:0]             wait_cnt;
  logic                            access_now;

  // last wait cycle of a pending request
  assign access_now = mem.req && !mem.done &&
                      (wait_cnt == CNT_BITS'(MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
      mem.done <= 1'b0;
    end else if (access_now) begin
      wait_cnt <= '0;
      mem.done <= 1'b1;
    end else begin
      mem.done <= 1'b0;
      if (mem.req && !mem.done) wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // each word starts out holding its own byte address
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < MEM_LINES; l++) begin
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
          mem_arr[l][w*W +: W] <= W'(l * LINE_BYTES + w * (W / 8));
        end
      end
    end else if (access_now) begin
      if (mem.op == cache_pkg::MEM_WRITE) begin
        mem_arr[mem.line_addr] <= mem.wline;
      end else begin
        mem.rline <= mem_arr[mem.line_addr];
      end
    end
  end

  // command fields held until done
  a_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    (mem.req && !mem.done) |=>
      (!mem.req || mem.done || ($stable(mem.op) && $stable(mem.line_addr)))
  );

endmodule

//--- hw/cache_controller.sv
`timescale 1ns/100ps

module cache_controller #(
  parameter int NUM_SETS  = 8,
  parameter int MEM_LINES = 256
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cache_pkg::ADDR_BITS-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [cache_pkg::WORD_BITS-1:0] wdata,
  input  logic [cache_pkg::STRB_BITS-1:0] wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output cache_pkg::axi_resp_t            bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [cache_pkg::ADDR_BITS-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [cache_pkg::WORD_BITS-1:0] rdata,
  output cache_pkg::axi_resp_t            rresp,
  output logic                            rvalid,
  input  logic                            rready,
  bank_if.ctrl                            way0,
  bank_if.ctrl                            way1,
  mem_if.ctrl                             mem
);
  localparam int SET_BITS      = $clog2(NUM_SETS);
  localparam int LINE_NUM_BITS = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS;
  localparam int MEM_ADDR_BITS = $clog2(MEM_LINES);

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WRITEBACK, FILL, ACCESS, RESPOND
  } state_t;

  state_t                          state;
  logic [cache_pkg::ADDR_BITS-1:0] req_addr;
  logic [cache_pkg::WORD_BITS-1:0] req_wdata;
  logic [cache_pkg::STRB_BITS-1:0] req_wstrb;
  logic                            req_write;
  logic                            way_sel;
  logic [NUM_SETS-1:0]             lru_old;
  cache_pkg::axi_resp_t            resp_q;

  logic                     accept_write;
  logic                     accept_read;
  logic [SET_BITS-1:0]      set_idx;
  logic [LINE_NUM_BITS-1:0] req_line;
  logic                     in_range;
  logic                     hit_any;
  logic                     victim;
  logic                     victim_dirty;
  logic [LINE_NUM_BITS-1:0] victim_line;

  // writes win over reads when both are offered
  assign accept_write = (state == IDLE) && awvalid && wvalid;
  assign accept_read  = (state == IDLE) && arvalid && !(awvalid && wvalid);
  assign awready = accept_write;
  assign wready  = accept_write;
  assign arready = accept_read;
  assign bresp   = resp_q;
  assign rresp   = resp_q;

  assign set_idx  = req_addr[cache_pkg::OFFSET_BITS +: SET_BITS];
  assign req_line = req_addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
  assign in_range = req_line < LINE_NUM_BITS'(MEM_LINES);
  assign hit_any  = way0.hit || way1.hit;

  // invalid way first, else the one marked old
  assign victim = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : lru_old[set_idx]);
  assign victim_dirty = victim ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty);
  assign victim_line  = victim ? {way1.victim_tag, set_idx} : {way0.victim_tag, set_idx};

  // both ways see the same request
  assign way0.addr      = req_addr;
  assign way1.addr      = req_addr;
  assign way0.wdata     = req_wdata;
  assign way1.wdata     = req_wdata;
  assign way0.wstrb     = req_wstrb;
  assign way1.wstrb     = req_wstrb;
  assign way0.fill_line = mem.rline;
  assign way1.fill_line = mem.rline;

  assign way0.word_we = (state == ACCESS) && req_write && !way_sel;
  assign way1.word_we = (state == ACCESS) && req_write && way_sel;
  assign way0.fill    = (state == FILL) && mem.req && mem.done && !way_sel;
  assign way1.fill    = (state == FILL) && mem.req && mem.done && way_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      mem.req <= 1'b0;
      lru_old <= '0;
    end else begin
      unique case (state)
        IDLE: begin
          if (accept_write || accept_read) state <= LOOKUP;
        end
        LOOKUP: begin
          if (!in_range) begin
            bvalid <= req_write;
            rvalid <= !req_write;
            state  <= RESPOND;
          end else if (hit_any) begin
            state <= ACCESS;
          end else if (victim_dirty) begin
            mem.req <= 1'b1;
            state   <= WRITEBACK;
          end else begin
            state <= FILL;
          end
        end
        WRITEBACK: begin
          if (mem.done) begin
            mem.req <= 1'b0;
            state   <= FILL;
          end
        end
        FILL: begin
          // one idle cycle after a write-back, then the read request
          if (!mem.req) begin
            mem.req <= 1'b1;
          end else if (mem.done) begin
            mem.req <= 1'b0;
            state   <= ACCESS;
          end
        end
        ACCESS: begin
          lru_old[set_idx] <= !way_sel;
          bvalid <= req_write;
          rvalid <= !req_write;
          state  <= RESPOND;
        end
        RESPOND: begin
          if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            state  <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // request fields, memory command and read data
  always_ff @(posedge clk) begin
    if (accept_write) begin
      req_addr  <= awaddr;
      req_wdata <= wdata;
      req_wstrb <= wstrb;
      req_write <= 1'b1;
    end else if (accept_read) begin
      req_addr  <= araddr;
      req_write <= 1'b0;
    end
    if (state == LOOKUP) begin
      way_sel       <= hit_any ? way1.hit : victim;
      resp_q        <= in_range ? cache_pkg::RESP_OKAY : cache_pkg::RESP_SLVERR;
      rdata         <= '0;
      mem.op        <= cache_pkg::MEM_WRITE;
      mem.line_addr <= victim_line[MEM_ADDR_BITS-1:0];
      mem.wline     <= victim ? way1.line_rdata : way0.line_rdata;
    end
    if (state == FILL && !mem.req) begin
      mem.op        <= cache_pkg::MEM_READ;
      mem.line_addr <= req_line[MEM_ADDR_BITS-1:0];
    end
    if (state == ACCESS && !req_write) begin
      rdata <= way_sel ? way1.word_rdata : way0.word_rdata;
    end
  end

  // a line lives in at most one way
  a_single_hit: assert property (
    @(posedge clk) disable iff (reset) !(way0.hit && way1.hit)
  );

endmodule

//--- hw/cache_bank.sv
`timescale 1ns/100ps

module cache_bank #(
  parameter int NUM_SETS = 8
) (
  input logic  clk,
  input logic  reset,
  bank_if.bank bank
);
  localparam int SET_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - SET_BITS - cache_pkg::OFFSET_BITS;
  localparam int WSEL_BITS = $clog2(cache_pkg::WORDS_PER_LINE);
  localparam int W = cache_pkg::WORD_BITS;

  // per-set storage
  logic [TAG_BITS-1:0]             tag_arr   [NUM_SETS];
  logic                            valid_arr [NUM_SETS];
  logic                            dirty_arr [NUM_SETS];
  logic [cache_pkg::LINE_BITS-1:0] data_arr  [NUM_SETS];

  logic [TAG_BITS-1:0]             addr_tag;
  logic [SET_BITS-1:0]             set_idx;
  logic [WSEL_BITS-1:0]            word_off;
  logic [cache_pkg::LINE_BITS-1:0] cur_line;

  // address split into tag, set, word and byte
  assign addr_tag = bank.addr[cache_pkg::ADDR_BITS-1 -: TAG_BITS];
  assign set_idx  = bank.addr[cache_pkg::OFFSET_BITS +: SET_BITS];
  assign word_off = bank.addr[cache_pkg::OFFSET_BITS-1 -: WSEL_BITS];

  assign cur_line = data_arr[set_idx];

  // lookup results come purely from addr
  assign bank.valid      = valid_arr[set_idx];
  assign bank.dirty      = dirty_arr[set_idx];
  assign bank.victim_tag = tag_arr[set_idx];
  assign bank.line_rdata = cur_line;
  assign bank.hit        = valid_arr[set_idx] && (tag_arr[set_idx] == addr_tag);

  // word mux
  always_comb begin
    unique case (word_off)
      2'd0:    bank.word_rdata = cur_line[0*W +: W];
      2'd1:    bank.word_rdata = cur_line[1*W +: W];
      2'd2:    bank.word_rdata = cur_line[2*W +: W];
      default: bank.word_rdata = cur_line[3*W +: W];
    endcase
  end

  // valid / dirty bits
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_arr[s] <= 1'b0;
        dirty_arr[s] <= 1'b0;
      end
    end else if (bank.fill) begin
      valid_arr[set_idx] <= 1'b1;
      dirty_arr[set_idx] <= 1'b0;
    end else if (bank.word_we) begin
      dirty_arr[set_idx] <= 1'b1;
    end
  end

  // tag and data take a whole line on fill or a byte merge on write
  always_ff @(posedge clk) begin
    if (bank.fill) begin
      tag_arr[set_idx]  <= addr_tag;
      data_arr[set_idx] <= bank.fill_line;
    end else if (bank.word_we) begin
      for (int b = 0; b < cache_pkg::STRB_BITS; b++) begin
        if (bank.wstrb[b]) begin
          data_arr[set_idx][word_off*W + b*8 +: 8] <= bank.wdata[b*8 +: 8];
        end
      end
    end
  end

  // controller must not fill and write the same way together
  a_fill_xor_write: assert property (
    @(posedge clk) disable iff (reset) !(bank.fill && bank.word_we)
  );

endmodule

//--- hw/cache_ifs.sv
`timescale 1ns/100ps

// controller to one cache way
interface bank_if #(
  parameter int NUM_SETS = 8
) ();
  localparam int SET_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS = cache_pkg::ADDR_BITS - SET_BITS - cache_pkg::OFFSET_BITS;

  logic [cache_pkg::ADDR_BITS-1:0] addr;
  logic                            word_we;
  logic [cache_pkg::WORD_BITS-1:0] wdata;
  logic [cache_pkg::STRB_BITS-1:0] wstrb;
  logic                            fill;
  logic [cache_pkg::LINE_BITS-1:0] fill_line;

  logic                            hit;
  logic                            valid;
  logic                            dirty;
  logic [TAG_BITS-1:0]             victim_tag;
  logic [cache_pkg::LINE_BITS-1:0] line_rdata;
  logic [cache_pkg::WORD_BITS-1:0] word_rdata;

  modport ctrl (
    output addr, word_we, wdata, wstrb, fill, fill_line,
    input  hit, valid, dirty, victim_tag, line_rdata, word_rdata
  );

  modport bank (
    input  addr, word_we, wdata, wstrb, fill, fill_line,
    output hit, valid, dirty, victim_tag, line_rdata, word_rdata
  );
endinterface

// controller to backing memory with one line per request
interface mem_if #(
  parameter int MEM_LINES = 256
) ();
  logic                            req;
  cache_pkg::mem_op_t              op;
  logic [$clog2(MEM_LINES)-1:0]    line_addr;
  logic [cache_pkg::LINE_BITS-1:0] wline;
  logic [cache_pkg::LINE_BITS-1:0] rline;
  logic                            done;

  modport ctrl (output req, op, line_addr, wline, input rline, done);
  modport mem  (input req, op, line_addr, wline, output rline, done);
endinterface

//--- hw/cache_pkg.sv
package cache_pkg;

  // word and line geometry
  localparam int WORD_BITS = 32;
  localparam int LINE_BITS = 128;
  localparam int STRB_BITS = WORD_BITS / 8;
  localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

  // byte offset inside a line where bits [3:2] pick the word
  localparam int OFFSET_BITS = 4;

  // AXI4-Lite address width
  localparam int ADDR_BITS = 32;

  // backing memory operation
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_t;

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage
